// File: Bender.yml
package:
  name: btb_subsys

sources:
  - btb_types_pkg.sv
  - btb_port_pkg.sv
  - btb_array.sv
  - btb_lookup.sv
  - btb_update.sv
  - btb.sv
  - btb_wrapper.sv
  - target: test
    files:
      - btb_checker.sv
      - tb_btb_wrapper.sv

// File: btb.sv
/*
 * BTB core
 * Fixed-priority arbiter between the lookup and update ports in
 * front of one single-ported array. Update write beats lookup read,
 * which beats update read; a losing access is dropped.
 */

`timescale 1ns/100ps

module btb #(
	parameter int BTB_INDEX_WIDTH = btb_types_pkg::BTB_INDEX_WIDTH_DEFAULT
) (
	input logic CLK,
	input logic nRST,

	// REQ stage
	input logic valid_REQ,
	input btb_types_pkg::pc_t full_PC_REQ,
	input btb_types_pkg::asid_t ASID_REQ,

	// RESP stage
	output btb_types_pkg::btb_pred_info_t [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0]
		pred_info_by_instr_RESP,
	output logic [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0] pred_lru_by_instr_RESP,
	output btb_types_pkg::btb_target_t [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0]
		target_by_instr_RESP,

	// Update 0
	input logic update0_valid,
	input btb_types_pkg::pc_t update0_start_full_PC,
	input btb_types_pkg::asid_t update0_ASID,

	// Update 1
	input btb_types_pkg::btb_pred_info_t update1_pred_info,
	input logic update1_pred_lru,
	input btb_types_pkg::pc_t update1_target_full_PC
);

	import btb_types_pkg::*;
	import btb_port_pkg::*;

	logic lkp_req_valid;
	btb_array_req_t lkp_req;
	logic lkp_req_ready;
	logic upd_req_valid;
	btb_array_req_t upd_req;
	logic upd_req_ready;

	logic grant_lkp;
	logic grant_upd;
	logic lkp_rdata_own;
	logic upd_rdata_own;

	logic array_req_valid;
	btb_array_req_t array_req;
	btb_set_t rdata;
	btb_slot_result_t [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] result_by_instr_RESP;

	// ----------------------------------------
	// Arbiter
	// Ready is the grant, built from the other port and own request kind
	assign lkp_req_ready = !(upd_req_valid && upd_req.write);
	assign upd_req_ready = upd_req.write || !lkp_req_valid;
	assign grant_lkp = lkp_req_valid && lkp_req_ready;
	assign grant_upd = upd_req_valid && upd_req_ready;

	assign array_req_valid = grant_lkp || grant_upd;
	assign array_req = grant_upd ? upd_req : lkp_req;

	// Owner of next cycle's read data
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			lkp_rdata_own <= 1'b0;
			upd_rdata_own <= 1'b0;
		end else begin
			lkp_rdata_own <= grant_lkp;
			upd_rdata_own <= grant_upd && !upd_req.write;
		end
	end

	// ----------------------------------------
	// Array and ports
	btb_array #(.BTB_INDEX_WIDTH(BTB_INDEX_WIDTH)) u_array (
		.CLK(CLK),
		.nRST(nRST),
		.req_valid(array_req_valid),
		.req(array_req),
		.rdata(rdata)
	);

	btb_lookup #(.BTB_INDEX_WIDTH(BTB_INDEX_WIDTH)) u_lookup (
		.CLK(CLK),
		.nRST(nRST),
		.valid_REQ(valid_REQ),
		.full_PC_REQ(full_PC_REQ),
		.ASID_REQ(ASID_REQ),
		.req_valid(lkp_req_valid),
		.req(lkp_req),
		.req_ready(lkp_req_ready),
		.rdata(rdata),
		.rdata_own(lkp_rdata_own),
		.result_by_instr_RESP(result_by_instr_RESP)
	);

	btb_update #(.BTB_INDEX_WIDTH(BTB_INDEX_WIDTH)) u_update (
		.CLK(CLK),
		.nRST(nRST),
		.update0_valid(update0_valid),
		.update0_start_full_PC(update0_start_full_PC),
		.update0_ASID(update0_ASID),
		.update1_pred_info(update1_pred_info),
		.update1_pred_lru(update1_pred_lru),
		.update1_target_full_PC(update1_target_full_PC),
		.req_valid(upd_req_valid),
		.req(upd_req),
		.req_ready(upd_req_ready),
		.rdata(rdata),
		.rdata_own(upd_rdata_own)
	);

	// Split per-slot results onto the output vectors
	always_comb begin
		for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
			pred_info_by_instr_RESP[s] = result_by_instr_RESP[s].pred_info;
			pred_lru_by_instr_RESP[s] = result_by_instr_RESP[s].lru;
			target_by_instr_RESP[s] = result_by_instr_RESP[s].target;
		end
	end

endmodule

// File: btb_array.sv
/*
 * BTB array
 * Single-ported set storage. A read returns the whole set one edge
 * later; a write updates one way in each masked slot and its LRU bit.
 */

`timescale 1ns/100ps

module btb_array #(
	parameter int BTB_INDEX_WIDTH = btb_types_pkg::BTB_INDEX_WIDTH_DEFAULT
) (
	input logic CLK,
	input logic nRST,
	input logic req_valid,
	input btb_port_pkg::btb_array_req_t req,
	output btb_port_pkg::btb_set_t rdata
);

	import btb_types_pkg::*;
	import btb_port_pkg::*;

	localparam int NUM_SETS = 2 ** BTB_INDEX_WIDTH;

	logic [BTB_INDEX_WIDTH-1:0] set_index;
	logic do_read;
	logic do_write;
	btb_set_t rd_set;

	btb_entry_t [BTB_NWAY_ENTRIES_PER_BLOCK-1:0][BTB_NUM_WAYS-1:0] entry_mem [NUM_SETS];
	logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0][BTB_NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] lru_q [NUM_SETS];

	assign set_index = req.index[BTB_INDEX_WIDTH-1:0];
	assign do_write = req_valid && req.write;
	assign do_read = req_valid && !req.write;

	// ----------------------------------------
	// Valid and LRU state
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				valid_q[i] <= '0;
				lru_q[i] <= '0;
			end
		end else if (do_write) begin
			for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
				if (req.slot_mask[s]) begin
					valid_q[set_index][s][req.way] <= req.entry.valid;
					lru_q[set_index][s] <= req.lru;
				end
			end
		end
	end

	// Tag, info and target storage
	always_ff @(posedge CLK) begin
		if (do_write) begin
			for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
				if (req.slot_mask[s]) begin
					entry_mem[set_index][s][req.way] <= req.entry;
				end
			end
		end
	end

	// ----------------------------------------
	// Read port
	// Valid bits come from the reset state, not the stored entry
	always_comb begin
		rd_set.lru = lru_q[set_index];
		for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
			for (int w = 0; w < BTB_NUM_WAYS; w++) begin
				rd_set.entry[s][w] = entry_mem[set_index][s][w];
				rd_set.entry[s][w].valid = valid_q[set_index][s][w];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (do_read) begin
			rdata <= rd_set;
		end
	end

endmodule

// File: btb_checker.sv
/*
 * BTB checker
 * Assertions on the array arbiter and the update port sequencing,
 * bound into the BTB core.
 */

`timescale 1ns/100ps

module btb_checker (
	input logic CLK,
	input logic nRST,
	input logic grant_lkp,
	input logic grant_upd,
	input logic lkp_req_valid,
	input logic upd_req_valid,
	input logic upd_req_write,
	input logic array_req_valid,
	input logic array_req_write
);

	int assertion_failures = 0;

	// ----------------------------------------
	// Arbiter
	one_grant: assert property (@(posedge CLK) disable iff (!nRST)
		!(grant_lkp && grant_upd))
	else begin
		$error("both ports granted in the same cycle");
		assertion_failures++;
	end

	// Writes reach the array only from the update port
	access_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
		array_req_valid |-> (array_req_write ? (upd_req_valid && upd_req_write)
			: (lkp_req_valid || (upd_req_valid && !upd_req_write))))
	else begin
		$error("array accessed without a matching valid request");
		assertion_failures++;
	end

	// Update sequencing
	write_follows_read: assert property (@(posedge CLK) disable iff (!nRST)
		(grant_upd && !upd_req_write) |=> (grant_upd && upd_req_write))
	else begin
		$error("granted update read not followed by a granted write");
		assertion_failures++;
	end

endmodule

bind btb btb_checker u_checker (
	.CLK(CLK),
	.nRST(nRST),
	.grant_lkp(grant_lkp),
	.grant_upd(grant_upd),
	.lkp_req_valid(lkp_req_valid),
	.upd_req_valid(upd_req_valid),
	.upd_req_write(upd_req.write),
	.array_req_valid(array_req_valid),
	.array_req_write(array_req.write)
);

// File: btb_lookup.sv
/*
 * BTB lookup port
 * Reads the set of the requested fetch block in REQ, compares both
 * ways of every slot against the held tag in RESP and returns
 * per-instruction prediction info, LRU bit and target.
 */

`timescale 1ns/100ps

module btb_lookup #(
	parameter int BTB_INDEX_WIDTH = btb_types_pkg::BTB_INDEX_WIDTH_DEFAULT
) (
	input logic CLK,
	input logic nRST,

	// REQ stage
	input logic valid_REQ,
	input btb_types_pkg::pc_t full_PC_REQ,
	input btb_types_pkg::asid_t ASID_REQ,

	// Array access
	output logic req_valid,
	output btb_port_pkg::btb_array_req_t req,
	input logic req_ready,
	input btb_port_pkg::btb_set_t rdata,
	input logic rdata_own,

	// RESP stage
	output btb_port_pkg::btb_slot_result_t [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0]
		result_by_instr_RESP
);

	import btb_types_pkg::*;
	import btb_port_pkg::*;

	btb_tag_t tag_REQ;
	btb_tag_t tag_RESP;
	logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0][BTB_NUM_WAYS-1:0] way_hit;

	// ----------------------------------------
	// REQ stage
	assign tag_REQ = btb_make_tag(full_PC_REQ, ASID_REQ, BTB_INDEX_WIDTH);
	assign req_valid = valid_REQ;

	always_comb begin
		req = '0;
		req.index = btb_index_t'(full_PC_REQ[BTB_INDEX_LSB +: BTB_INDEX_WIDTH]);
	end

	// Tag kept only for an access that reached the array
	always_ff @(posedge CLK) begin
		if (req_valid && req_ready) begin
			tag_RESP <= tag_REQ;
		end
	end

	// ----------------------------------------
	// RESP stage
	always_comb begin
		for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
			for (int w = 0; w < BTB_NUM_WAYS; w++) begin
				way_hit[s][w] = rdata.entry[s][w].valid
					&& (rdata.entry[s][w].tag == tag_RESP);
			end
		end
	end

	// Way 0 wins a double hit
	always_comb begin
		result_by_instr_RESP = '0;
		if (rdata_own) begin
			for (int s = 0; s < BTB_NWAY_ENTRIES_PER_BLOCK; s++) begin
				result_by_instr_RESP[s].lru = rdata.lru[s];
				if (way_hit[s][0]) begin
					result_by_instr_RESP[s].pred_info = rdata.entry[s][0].pred_info;
					result_by_instr_RESP[s].target = rdata.entry[s][0].target;
				end else if (way_hit[s][1]) begin
					result_by_instr_RESP[s].pred_info = rdata.entry[s][1].pred_info;
					result_by_instr_RESP[s].target = rdata.entry[s][1].target;
				end
			end
		end
	end

endmodule

// File: btb_port_pkg.sv
/*
 * BTB port types
 * Array entry and set layout, the shared array request, the per-slot
 * lookup result and the update port phases.
 */

package btb_port_pkg;

	import btb_types_pkg::*;

	// ----------------------------------------
	// Array contents
	typedef struct packed {
		logic valid;
		btb_tag_t tag;
		btb_pred_info_t pred_info;
		btb_target_t target;
	} btb_entry_t;

	// One set across all slots of a fetch block
	typedef struct packed {
		btb_entry_t [BTB_NWAY_ENTRIES_PER_BLOCK-1:0][BTB_NUM_WAYS-1:0] entry;
		logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] lru;
	} btb_set_t;

	// ----------------------------------------
	// Requests and results
	typedef struct packed {
		btb_index_t index;
		logic write;
		btb_slot_mask_t slot_mask;
		logic way;
		btb_entry_t entry;
		logic lru;
	} btb_array_req_t;

	typedef struct packed {
		btb_pred_info_t pred_info;
		logic lru;
		btb_target_t target;
	} btb_slot_result_t;

	typedef enum logic {
		UPD_IDLE,
		UPD_WRITE
	} btb_upd_phase_e;

endpackage

// File: btb_subsys.f
btb_types_pkg.sv
btb_port_pkg.sv
btb_array.sv
btb_lookup.sv
btb_update.sv
btb.sv
btb_wrapper.sv
btb_checker.sv
tb_btb_wrapper.sv

// File: btb_types_pkg.sv
/*
 * BTB types
 * Widths, vector types and fixed geometry of the branch target buffer,
 * plus the PC field positions and the ASID-mixed tag fold.
 */

package btb_types_pkg;

	// ----------------------------------------
	// Widths
	localparam int ASID_WIDTH = 9;
	localparam int BTB_PRED_INFO_WIDTH = 8;
	localparam int BTB_TARGET_WIDTH = 10;
	localparam int BTB_TAG_WIDTH = 12;

	// ----------------------------------------
	// Geometry
	localparam int BTB_NWAY_ENTRIES_PER_BLOCK = 4;
	localparam int BTB_NUM_WAYS = 2;
	localparam int BTB_INDEX_WIDTH_DEFAULT = 5;
	// Widest index the request struct can carry
	localparam int BTB_INDEX_WIDTH_MAX = 8;
	localparam int BTB_SLOT_WIDTH = $clog2(BTB_NWAY_ENTRIES_PER_BLOCK);

	// PC field positions
	localparam int BTB_SLOT_LSB = 2;
	localparam int BTB_INDEX_LSB = 4;
	localparam int BTB_TARGET_LSB = 2;

	// Upper PC bits are folded in chunks of the tag width
	localparam int BTB_TAG_FOLDS = (32 + BTB_TAG_WIDTH - 1) / BTB_TAG_WIDTH;
	localparam int BTB_TAG_FOLD_BITS = BTB_TAG_FOLDS * BTB_TAG_WIDTH;

	typedef logic [31:0] pc_t;
	typedef logic [ASID_WIDTH-1:0] asid_t;
	// Zero means no branch in this slot
	typedef logic [BTB_PRED_INFO_WIDTH-1:0] btb_pred_info_t;
	// Target PC bits 11:2
	typedef logic [BTB_TARGET_WIDTH-1:0] btb_target_t;
	typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;
	typedef logic [BTB_INDEX_WIDTH_MAX-1:0] btb_index_t;
	typedef logic [BTB_SLOT_WIDTH-1:0] btb_slot_t;
	typedef logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] btb_slot_mask_t;

	// Tag from the PC bits above the index, folded and mixed with the ASID
	function automatic btb_tag_t btb_make_tag(pc_t pc, asid_t asid, int unsigned index_width);
		logic [BTB_TAG_FOLD_BITS-1:0] upper;
		btb_tag_t tag;
		upper = BTB_TAG_FOLD_BITS'(pc >> (BTB_INDEX_LSB + index_width));
		tag = btb_tag_t'(asid);
		for (int i = 0; i < BTB_TAG_FOLDS; i++) begin
			tag ^= upper[i*BTB_TAG_WIDTH +: BTB_TAG_WIDTH];
		end
		return tag;
	endfunction

endpackage

// File: btb_update.sv
/*
 * BTB update port
 * Two-stage update. update0 reads the set and holds index, slot and
 * tag; the next cycle picks the hit way or the LRU victim and writes
 * the update1 info, target and LRU bit.
 */

`timescale 1ns/100ps

module btb_update #(
	parameter int BTB_INDEX_WIDTH = btb_types_pkg::BTB_INDEX_WIDTH_DEFAULT
) (
	input logic CLK,
	input logic nRST,

	// Update 0
	input logic update0_valid,
	input btb_types_pkg::pc_t update0_start_full_PC,
	input btb_types_pkg::asid_t update0_ASID,

	// Update 1
	input btb_types_pkg::btb_pred_info_t update1_pred_info,
	input logic update1_pred_lru,
	input btb_types_pkg::pc_t update1_target_full_PC,

	// Array access
	output logic req_valid,
	output btb_port_pkg::btb_array_req_t req,
	input logic req_ready,
	input btb_port_pkg::btb_set_t rdata,
	input logic rdata_own
);

	import btb_types_pkg::*;
	import btb_port_pkg::*;

	btb_upd_phase_e phase;
	btb_upd_phase_e phase_n;

	btb_index_t upd_index;
	btb_slot_t upd_slot;
	btb_tag_t upd_tag;

	logic [BTB_NUM_WAYS-1:0] way_hit;
	logic victim_way;
	logic write_way;

	// ----------------------------------------
	// Phase FSM
	always_comb begin
		phase_n = phase;
		case (phase)
			UPD_IDLE: if (update0_valid) phase_n = UPD_WRITE;
			UPD_WRITE: if (req_ready) phase_n = UPD_IDLE;
			default: phase_n = UPD_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			phase <= UPD_IDLE;
		end else begin
			phase <= phase_n;
		end
	end

	// Held update0 fields for the write cycle
	always_ff @(posedge CLK) begin
		if (phase == UPD_IDLE && update0_valid) begin
			upd_index <= btb_index_t'(update0_start_full_PC[BTB_INDEX_LSB +: BTB_INDEX_WIDTH]);
			upd_slot <= update0_start_full_PC[BTB_SLOT_LSB +: BTB_SLOT_WIDTH];
			upd_tag <= btb_make_tag(update0_start_full_PC, update0_ASID, BTB_INDEX_WIDTH);
		end
	end

	// ----------------------------------------
	// Way choice
	// A lost read counts as a miss with victim way 0
	always_comb begin
		for (int w = 0; w < BTB_NUM_WAYS; w++) begin
			way_hit[w] = rdata_own && rdata.entry[upd_slot][w].valid
				&& (rdata.entry[upd_slot][w].tag == upd_tag);
		end
	end

	assign victim_way = rdata_own ? rdata.lru[upd_slot] : 1'b0;
	assign write_way = way_hit[0] ? 1'b0 : (way_hit[1] ? 1'b1 : victim_way);

	// ----------------------------------------
	// Array request
	always_comb begin
		req = '0;
		if (phase == UPD_WRITE) begin
			req_valid = 1'b1;
			req.index = upd_index;
			req.write = 1'b1;
			req.slot_mask = btb_slot_mask_t'(1) << upd_slot;
			req.way = write_way;
			req.entry.valid = 1'b1;
			req.entry.tag = upd_tag;
			req.entry.pred_info = update1_pred_info;
			req.entry.target = update1_target_full_PC[BTB_TARGET_LSB +: BTB_TARGET_WIDTH];
			req.lru = update1_pred_lru;
		end else begin
			req_valid = update0_valid;
			req.index = btb_index_t'(update0_start_full_PC[BTB_INDEX_LSB +: BTB_INDEX_WIDTH]);
		end
	end

endmodule

// File: btb_wrapper.sv
/*
 * BTB wrapper
 * Top level of the subsystem. One register stage on every input and
 * every output around the BTB core, and the index width setting.
 */

`timescale 1ns/100ps

module btb_wrapper #(
	parameter int BTB_INDEX_WIDTH = btb_types_pkg::BTB_INDEX_WIDTH_DEFAULT
) (
	input logic CLK,
	input logic nRST,

	// REQ stage
	input logic next_valid_REQ,
	input btb_types_pkg::pc_t next_full_PC_REQ,
	input btb_types_pkg::asid_t next_ASID_REQ,

	// RESP stage
	output btb_types_pkg::btb_pred_info_t [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0]
		last_pred_info_by_instr_RESP,
	output logic [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0] last_pred_lru_by_instr_RESP,
	output btb_types_pkg::btb_target_t [btb_types_pkg::BTB_NWAY_ENTRIES_PER_BLOCK-1:0]
		last_target_by_instr_RESP,

	// Update 0
	input logic next_update0_valid,
	input btb_types_pkg::pc_t next_update0_start_full_PC,
	input btb_types_pkg::asid_t next_update0_ASID,

	// Update 1
	input btb_types_pkg::btb_pred_info_t next_update1_pred_info,
	input logic next_update1_pred_lru,
	input btb_types_pkg::pc_t next_update1_target_full_PC
);

	import btb_types_pkg::*;

	// ----------------------------------------
	// Core side signals
	logic valid_REQ;
	pc_t full_PC_REQ;
	asid_t ASID_REQ;

	btb_pred_info_t [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] pred_info_by_instr_RESP;
	logic [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] pred_lru_by_instr_RESP;
	btb_target_t [BTB_NWAY_ENTRIES_PER_BLOCK-1:0] target_by_instr_RESP;

	logic update0_valid;
	pc_t update0_start_full_PC;
	asid_t update0_ASID;

	btb_pred_info_t update1_pred_info;
	logic update1_pred_lru;
	pc_t update1_target_full_PC;

	btb #(.BTB_INDEX_WIDTH(BTB_INDEX_WIDTH)) u_btb (.*);

	// ----------------------------------------
	// Boundary registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			valid_REQ <= 1'b0;
			full_PC_REQ <= '0;
			ASID_REQ <= '0;
			last_pred_info_by_instr_RESP <= '0;
			last_pred_lru_by_instr_RESP <= '0;
			last_target_by_instr_RESP <= '0;
			update0_valid <= 1'b0;
			update0_start_full_PC <= '0;
			update0_ASID <= '0;
			update1_pred_info <= '0;
			update1_pred_lru <= 1'b0;
			update1_target_full_PC <= '0;
		end else begin
			valid_REQ <= next_valid_REQ;
			full_PC_REQ <= next_full_PC_REQ;
			ASID_REQ <= next_ASID_REQ;
			last_pred_info_by_instr_RESP <= pred_info_by_instr_RESP;
			last_pred_lru_by_instr_RESP <= pred_lru_by_instr_RESP;
			last_target_by_instr_RESP <= target_by_instr_RESP;
			update0_valid <= next_update0_valid;
			update0_start_full_PC <= next_update0_start_full_PC;
			update0_ASID <= next_update0_ASID;
			update1_pred_info <= next_update1_pred_info;
			update1_pred_lru <= next_update1_pred_lru;
			update1_target_full_PC <= next_update1_target_full_PC;
		end
	end

endmodule

// File: tb_btb_wrapper.sv
/*
 * BTB wrapper testbench
 * Directed tests against a reference model of the 2-way BTB: reset
 * state, write then hit, ASID mixing, LRU replacement, in-place
 * rewrite and lookup/update contention on the single array port.
 */

`timescale 1ns/100ps

module tb_btb_wrapper;

	import btb_types_pkg::*;

	localparam int INDEX_WIDTH = 5;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 40;
	localparam int SLOTS = BTB_NWAY_ENTRIES_PER_BLOCK;

	logic CLK;
	logic nRST;
	logic next_valid_REQ;
	pc_t next_full_PC_REQ;
	asid_t next_ASID_REQ;
	btb_pred_info_t [SLOTS-1:0] last_pred_info_by_instr_RESP;
	logic [SLOTS-1:0] last_pred_lru_by_instr_RESP;
	btb_target_t [SLOTS-1:0] last_target_by_instr_RESP;
	logic next_update0_valid;
	pc_t next_update0_start_full_PC;
	asid_t next_update0_ASID;
	btb_pred_info_t next_update1_pred_info;
	logic next_update1_pred_lru;
	pc_t next_update1_target_full_PC;

	// Reference model, slot key = index * SLOTS + slot, entry key = slot key * 2 + way
	btb_tag_t model_tag [int];
	btb_pred_info_t model_info [int];
	btb_target_t model_target [int];
	logic model_lru [int];

	int errors;
	int checks;
	int tests_run;
	pc_t pc_a;
	pc_t pc_b;
	pc_t pc_c;
	asid_t asid_a;

	btb_wrapper #(.BTB_INDEX_WIDTH(INDEX_WIDTH)) dut_i (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ----------------------------------------
	// Reference model
	function automatic btb_tag_t expected_tag(pc_t pc, asid_t asid);
		logic [31:0] upper;
		btb_tag_t tag;
		upper = pc >> (4 + INDEX_WIDTH);
		tag = {3'b000, asid};
		while (upper != 0) begin
			tag = tag ^ upper[11:0];
			upper = upper >> 12;
		end
		return tag;
	endfunction

	function automatic int slot_key(pc_t pc, int slot);
		return int'((pc >> 4) & ((32'd1 << INDEX_WIDTH) - 1)) * SLOTS + slot;
	endfunction

	function automatic logic way_matches(int key, int way, btb_tag_t tag);
		if (!model_tag.exists(key * 2 + way)) begin
			return 1'b0;
		end
		return model_tag[key * 2 + way] == tag;
	endfunction

	function automatic void model_update(pc_t pc, asid_t asid, btb_pred_info_t info,
		logic lru, pc_t target);
		int key;
		int way;
		btb_tag_t tag;
		key = slot_key(pc, pc[3:2]);
		tag = expected_tag(pc, asid);
		if (way_matches(key, 0, tag)) begin
			way = 0;
		end else if (way_matches(key, 1, tag)) begin
			way = 1;
		end else begin
			way = model_lru.exists(key) ? int'(model_lru[key]) : 0;
		end
		model_tag[key * 2 + way] = tag;
		model_info[key * 2 + way] = info;
		model_target[key * 2 + way] = target[11:2];
		model_lru[key] = lru;
	endfunction

	// ----------------------------------------
	// Checks
	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error: %s = 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic check_slots(pc_t pc, asid_t asid);
		int key;
		int hit_key;
		btb_tag_t tag;
		tag = expected_tag(pc, asid);
		for (int s = 0; s < SLOTS; s++) begin
			key = slot_key(pc, s);
			hit_key = -1;
			// Way 0 wins a double hit
			if (way_matches(key, 0, tag)) begin
				hit_key = key * 2;
			end else if (way_matches(key, 1, tag)) begin
				hit_key = key * 2 + 1;
			end
			check_value($sformatf("last_pred_info_by_instr_RESP[%0d]", s),
				last_pred_info_by_instr_RESP[s], hit_key < 0 ? 0 : model_info[hit_key]);
			check_value($sformatf("last_target_by_instr_RESP[%0d]", s),
				last_target_by_instr_RESP[s], hit_key < 0 ? 0 : model_target[hit_key]);
			check_value($sformatf("last_pred_lru_by_instr_RESP[%0d]", s),
				last_pred_lru_by_instr_RESP[s], model_lru.exists(key) ? model_lru[key] : 0);
		end
	endtask

	task automatic check_all_zero();
		for (int s = 0; s < SLOTS; s++) begin
			check_value($sformatf("last_pred_info_by_instr_RESP[%0d]", s),
				last_pred_info_by_instr_RESP[s], 0);
			check_value($sformatf("last_target_by_instr_RESP[%0d]", s),
				last_target_by_instr_RESP[s], 0);
			check_value($sformatf("last_pred_lru_by_instr_RESP[%0d]", s),
				last_pred_lru_by_instr_RESP[s], 0);
		end
	endtask

	// ----------------------------------------
	// Drivers
	// update0 in one cycle, its update1 fields in the next
	task automatic drive_update(pc_t pc, asid_t asid, btb_pred_info_t info, logic lru,
		pc_t target);
		@(posedge CLK);
		next_update0_valid <= 1'b1;
		next_update0_start_full_PC <= pc;
		next_update0_ASID <= asid;
		@(posedge CLK);
		next_update0_valid <= 1'b0;
		next_update1_pred_info <= info;
		next_update1_pred_lru <= lru;
		next_update1_target_full_PC <= target;
		model_update(pc, asid, info, lru, target);
	endtask

	// Result is on the outputs three edges after the request
	task automatic run_lookup(pc_t pc, asid_t asid);
		@(posedge CLK);
		next_valid_REQ <= 1'b1;
		next_full_PC_REQ <= pc;
		next_ASID_REQ <= asid;
		@(posedge CLK);
		next_valid_REQ <= 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		check_slots(pc, asid);
	endtask

	function automatic pc_t random_pc();
		return pc_t'($urandom) & 32'hffff_fffc;
	endfunction

	task automatic finish_test(string name, int start_errors);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
	endtask

	// ----------------------------------------
	// Tests
	task automatic test_reset_idle();
		int start_errors;
		start_errors = errors;
		@(negedge CLK);
		check_all_zero();
		run_lookup(random_pc(), asid_t'($urandom));
		finish_test("reset and idle", start_errors);
	endtask

	task automatic test_write_then_hit();
		int start_errors;
		start_errors = errors;
		pc_a = random_pc();
		asid_a = asid_t'($urandom);
		drive_update(pc_a, asid_a, btb_pred_info_t'($urandom_range(255, 1)), 1'b1, random_pc());
		run_lookup(pc_a, asid_a);
		finish_test("write then hit", start_errors);
	endtask

	task automatic test_asid_miss();
		int start_errors;
		start_errors = errors;
		run_lookup(pc_a, asid_a ^ 9'h1ff);
		finish_test("other ASID misses", start_errors);
	endtask

	// Bits 20 and 21 sit above the index, so only the tag changes
	task automatic test_lru_replace();
		int start_errors;
		start_errors = errors;
		pc_a = random_pc();
		pc_b = pc_a ^ 32'h0010_0000;
		pc_c = pc_a ^ 32'h0020_0000;
		asid_a = asid_t'($urandom);
		drive_update(pc_a, asid_a, btb_pred_info_t'($urandom_range(255, 1)), 1'b1, random_pc());
		drive_update(pc_b, asid_a, btb_pred_info_t'($urandom_range(255, 1)), 1'b0, random_pc());
		run_lookup(pc_a, asid_a);
		run_lookup(pc_b, asid_a);
		drive_update(pc_c, asid_a, btb_pred_info_t'($urandom_range(255, 1)), 1'b1, random_pc());
		run_lookup(pc_a, asid_a);
		run_lookup(pc_c, asid_a);
		finish_test("LRU replacement", start_errors);
	endtask

	task automatic test_rewrite_in_place();
		int start_errors;
		start_errors = errors;
		drive_update(pc_b, asid_a, btb_pred_info_t'($urandom_range(255, 1)), 1'b0, random_pc());
		run_lookup(pc_b, asid_a);
		run_lookup(pc_c, asid_a);
		finish_test("rewrite in place", start_errors);
	endtask

	// First lookup meets the write cycle, the second one follows it
	task automatic test_update_contention();
		int start_errors;
		pc_t pc;
		asid_t asid;
		btb_pred_info_t info;
		pc_t target;
		start_errors = errors;
		pc = random_pc();
		asid = asid_t'($urandom);
		info = btb_pred_info_t'($urandom_range(255, 1));
		target = random_pc();
		@(posedge CLK);
		next_update0_valid <= 1'b1;
		next_update0_start_full_PC <= pc;
		next_update0_ASID <= asid;
		@(posedge CLK);
		next_update0_valid <= 1'b0;
		next_update1_pred_info <= info;
		next_update1_pred_lru <= 1'b1;
		next_update1_target_full_PC <= target;
		next_valid_REQ <= 1'b1;
		next_full_PC_REQ <= pc;
		next_ASID_REQ <= asid;
		@(posedge CLK);
		@(posedge CLK);
		next_valid_REQ <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		check_all_zero();
		model_update(pc, asid, info, 1'b1, target);
		@(posedge CLK);
		@(negedge CLK);
		check_slots(pc, asid);
		finish_test("lookup against update write", start_errors);
	endtask

	// ----------------------------------------
	// Main sequence
	initial begin
		void'($urandom(81));
		errors = 0;
		checks = 0;
		tests_run = 0;
		CLK = 1'b0;
		nRST = 1'b0;
		next_valid_REQ = 1'b0;
		next_full_PC_REQ = '0;
		next_ASID_REQ = '0;
		next_update0_valid = 1'b0;
		next_update0_start_full_PC = '0;
		next_update0_ASID = '0;
		next_update1_pred_info = '0;
		next_update1_pred_lru = 1'b0;
		next_update1_target_full_PC = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		test_reset_idle();
		test_write_then_hit();
		test_asid_miss();
		test_lru_replace();
		test_rewrite_in_place();
		test_update_contention();
		errors = errors + dut_i.u_btb.u_checker.assertion_failures;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
		$display("timeout: the tests did not complete within the cycle budget");
		$display(">>> FAIL");
		$finish;
	end

endmodule
